//--- verif/npu_trace.txt
// thr pulses class start conv1_rd conv1_byp conv2_rd conv2_byp conv3_rd conv3_byp fc1_rd fc2_rd
// Hex values, fc1_rd counts one half, expected counts are for IMG_DIM 8
// Zero threshold never starts
00 04 00 0 000 000 000 000 000 000 00 00
// Fewer rows than the threshold
0a 06 00 0 000 000 000 000 000 000 00 00
// Rows match the threshold exactly
08 08 13 1 6c0 114 480 160 240 140 18 40
// Rows keep arriving after the start
02 03 07 1 6c0 114 480 160 240 140 18 40
// Largest threshold and top class
3f 3f 1f 1 6c0 114 480 160 240 140 18 40

//--- tb.f
design/npu_pkg.sv
design/npu_layer_sequencer.sv
design/conv_window_walker.sv
design/fc_vector_walker.sv
design/act_rd_arbiter.sv
design/npu_control_top.sv
verif/npu_control_checker.sv
verif/npu_control_tb.sv

//--- Makefile
SIM        = verilator
TOP        = npu_control_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/npu_control_tb.sv
`timescale 1ns/1ns

module npu_control_tb;
   import npu_pkg::*;

   localparam int IMG_DIM    = 8;
   localparam int NUM_SCEN   = 5;
   localparam int NUM_FIELDS = 12;

   // Column positions inside one trace line
   localparam int F_THR    = 0;
   localparam int F_PULSES = 1;
   localparam int F_CLASS  = 2;
   localparam int F_START  = 3;
   localparam int F_CONV1  = 4;
   localparam int F_CONV2  = 6;
   localparam int F_CONV3  = 8;
   localparam int F_FC1    = 10;
   localparam int F_FC2    = 11;

   logic      npu_clk;
   logic      npu_rst_n;
   logic      cfg_write_row;
   row_cnt_t  cfg_start_threshold;
   logic      softmax_result_valid;
   class_t    softmax_class;
   logic      npu_active;
   logic      npu_done;
   layer_e    npu_layer_in_progress;
   row_cnt_t  img_num_rows_written;
   class_t    npu_class_predicted;
   logic      act_mem_rd_en;
   act_addr_t act_mem_rd_addr;
   logic      act_mem_rd_bypass;

   logic [15:0] trace_mem [0:NUM_SCEN*NUM_FIELDS-1];
   logic        trace_loaded;
   int          rd_count [0:7];
   int          byp_count [0:7];
   layer_e      prev_layer;

   npu_control_top #(
      .IMG_DIM (IMG_DIM)
   ) uut (
      .npu_clk               (npu_clk),
      .npu_rst_n             (npu_rst_n),
      .cfg_write_row         (cfg_write_row),
      .cfg_start_threshold   (cfg_start_threshold),
      .softmax_result_valid  (softmax_result_valid),
      .softmax_class         (softmax_class),
      .npu_active            (npu_active),
      .npu_done              (npu_done),
      .npu_layer_in_progress (npu_layer_in_progress),
      .img_num_rows_written  (img_num_rows_written),
      .npu_class_predicted   (npu_class_predicted),
      .act_mem_rd_en         (act_mem_rd_en),
      .act_mem_rd_addr       (act_mem_rd_addr),
      .act_mem_rd_bypass     (act_mem_rd_bypass)
   );

   initial begin
      npu_clk = 1'b0;
      forever #50 npu_clk = ~npu_clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic fail_run(input string why);
      $display(">>> FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check_value(input string name, input int actual, input int expected);
      if (actual != expected) begin
         $display("ERROR at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
         fail_run("Value mismatch");
      end
   endtask

   function automatic int trace_field(input int s, input int f);
      return int'(trace_mem[s*NUM_FIELDS + f]);
   endfunction

   // Layers follow the encoding order and done wraps back to idle
   function automatic layer_e following_layer(input layer_e l);
      return layer_e'(3'(l) + 3'd1);
   endfunction

   function automatic bit layer_is_running(input layer_e l);
      return (l != LAYER_IDLE) && (l != LAYER_DONE);
   endfunction

   // Each layer reads the output section of the layer before it
   function automatic bit addr_in_section(input layer_e l, input act_addr_t a);
      int lo;
      int hi;
      case (l)
         LAYER_CONV1: begin
            lo = int'(INPUT_IMAGE_BASE);
            hi = int'(CONV1_OUT_BASE);
         end
         LAYER_CONV2: begin
            lo = int'(CONV1_OUT_BASE);
            hi = int'(CONV2_OUT_BASE);
         end
         LAYER_CONV3: begin
            lo = int'(CONV2_OUT_BASE);
            hi = int'(CONV3_OUT_BASE);
         end
         LAYER_FC1: begin
            lo = int'(CONV3_OUT_BASE);
            hi = int'(FC1_OUT_BASE);
         end
         LAYER_FC2: begin
            lo = int'(FC1_OUT_BASE);
            hi = 8192;
         end
         default: begin
            lo = 0;
            hi = 0;
         end
      endcase
      return (int'(a) >= lo) && (int'(a) < hi);
   endfunction

   ////////////////////////////////////////
   // Read port and layer monitor
   ////////////////////////////////////////

   always @(negedge npu_clk) begin
      if (!npu_rst_n) begin
         prev_layer = LAYER_IDLE;
      end else begin
         if (act_mem_rd_en) begin
            rd_count[npu_layer_in_progress] = rd_count[npu_layer_in_progress] + 1;
            if (act_mem_rd_bypass) begin
               byp_count[npu_layer_in_progress] = byp_count[npu_layer_in_progress] + 1;
            end else begin
               check_value("act_mem_rd_addr in section",
                           int'(addr_in_section(npu_layer_in_progress, act_mem_rd_addr)), 1);
            end
         end
         if (npu_layer_in_progress != prev_layer) begin
            check_value("npu_layer_in_progress", int'(npu_layer_in_progress),
                        int'(following_layer(prev_layer)));
            prev_layer = npu_layer_in_progress;
         end
         check_value("npu_active", int'(npu_active),
                     int'(layer_is_running(npu_layer_in_progress)));
         check_value("npu_done", int'(npu_done), int'(npu_layer_in_progress == LAYER_DONE));
      end
   end

   ////////////////////////////////////////
   // Scenarios
   ////////////////////////////////////////

   task automatic apply_reset();
      for (int l = 0; l < 8; l++) begin
         rd_count[l]  = 0;
         byp_count[l] = 0;
      end
      npu_rst_n <= 1'b0;
      repeat (3) @(posedge npu_clk);
      npu_rst_n <= 1'b1;
      @(negedge npu_clk);
      check_value("act_mem_rd_en", int'(act_mem_rd_en), 0);
      check_value("npu_active", int'(npu_active), 0);
      check_value("npu_done", int'(npu_done), 0);
      check_value("npu_layer_in_progress", int'(npu_layer_in_progress), int'(LAYER_IDLE));
   endtask

   task automatic check_counts(input int s);
      check_value("conv1 act_mem_rd_en count", rd_count[LAYER_CONV1], trace_field(s, F_CONV1));
      check_value("conv1 bypass count", byp_count[LAYER_CONV1], trace_field(s, F_CONV1 + 1));
      check_value("conv2 act_mem_rd_en count", rd_count[LAYER_CONV2], trace_field(s, F_CONV2));
      check_value("conv2 bypass count", byp_count[LAYER_CONV2], trace_field(s, F_CONV2 + 1));
      check_value("conv3 act_mem_rd_en count", rd_count[LAYER_CONV3], trace_field(s, F_CONV3));
      check_value("conv3 bypass count", byp_count[LAYER_CONV3], trace_field(s, F_CONV3 + 1));
      // Both fc1 halves run under the same layer code
      check_value("fc1 act_mem_rd_en count", rd_count[LAYER_FC1], 2 * trace_field(s, F_FC1));
      check_value("fc1 bypass count", byp_count[LAYER_FC1], 0);
      check_value("fc2 act_mem_rd_en count", rd_count[LAYER_FC2], trace_field(s, F_FC2));
      check_value("fc2 bypass count", byp_count[LAYER_FC2], 0);
   endtask

   task automatic run_scenario(input int s);
      int pulses;
      int cls;
      bit started;
      pulses  = trace_field(s, F_PULSES);
      cls     = trace_field(s, F_CLASS);
      started = (trace_field(s, F_START) != 0);
      @(posedge npu_clk);
      apply_reset();
      @(posedge npu_clk);
      cfg_start_threshold <= row_cnt_t'(trace_field(s, F_THR));
      for (int p = 0; p < pulses; p++) begin
         @(posedge npu_clk);
         cfg_write_row <= 1'b1;
         @(posedge npu_clk);
         cfg_write_row <= 1'b0;
      end
      repeat (2) @(posedge npu_clk);
      @(negedge npu_clk);
      check_value("img_num_rows_written", int'(img_num_rows_written), pulses);
      check_value("npu_active", int'(npu_active), int'(started));
      if (started) begin
         while (npu_layer_in_progress != LAYER_SOFTMAX) @(negedge npu_clk);
         @(posedge npu_clk);
         softmax_result_valid <= 1'b1;
         softmax_class        <= class_t'(cls);
         @(posedge npu_clk);
         softmax_result_valid <= 1'b0;
         @(negedge npu_clk);
         check_value("npu_done", int'(npu_done), 1);
         check_value("npu_class_predicted", int'(npu_class_predicted), cls);
         check_counts(s);
         // Next host row rearms the unit
         @(posedge npu_clk);
         cfg_write_row <= 1'b1;
         @(posedge npu_clk);
         cfg_write_row <= 1'b0;
         @(negedge npu_clk);
         check_value("npu_layer_in_progress", int'(npu_layer_in_progress), int'(LAYER_IDLE));
         check_value("img_num_rows_written", int'(img_num_rows_written), 0);
      end else begin
         repeat (8) @(posedge npu_clk);
         @(negedge npu_clk);
         check_counts(s);
      end
   endtask

   initial begin
      npu_rst_n            = 1'b0;
      cfg_write_row        = 1'b0;
      cfg_start_threshold  = '0;
      softmax_result_valid = 1'b0;
      softmax_class        = '0;
      trace_loaded         = 1'b0;
      $readmemh("verif/npu_trace.txt", trace_mem);
      trace_loaded = 1'b1;
      for (int s = 0; s < NUM_SCEN; s++) begin
         run_scenario(s);
      end
      $display(">>> PASS");
      $finish;
   end

   // Watchdog sized from the longest traced run
   initial begin
      int max_reads;
      int reads;
      int limit;
      max_reads = 0;
      wait (trace_loaded);
      for (int s = 0; s < NUM_SCEN; s++) begin
         reads = trace_field(s, F_CONV1) + trace_field(s, F_CONV2) + trace_field(s, F_CONV3) +
                 2 * trace_field(s, F_FC1) + trace_field(s, F_FC2);
         if (reads > max_reads) begin
            max_reads = reads;
         end
      end
      limit = NUM_SCEN * (2 * max_reads + 6 * RESULT_WAIT_CYCLES + 256);
      repeat (limit) @(posedge npu_clk);
      fail_run("Timeout: the run did not finish within the expected number of cycles");
   end

endmodule

//--- verif/npu_control_checker.sv
`timescale 1ns/1ns

module npu_control_checker (
   input logic npu_clk,
   input logic npu_rst_n,
   input logic act_mem_rd_en,
   input logic act_mem_rd_bypass,
   input logic npu_active,
   input logic npu_done
);

   // A padded tap still takes a read slot on the port
   bypass_needs_en: assert property (
      @(posedge npu_clk) disable iff (!npu_rst_n) act_mem_rd_bypass |-> act_mem_rd_en
   ) else $error("act_mem_rd_bypass high without act_mem_rd_en");

   rd_only_when_active: assert property (
      @(posedge npu_clk) disable iff (!npu_rst_n) act_mem_rd_en |-> npu_active
   ) else $error("act_mem_rd_en high outside an active run");

   // Done is only entered after the run has ended
   active_done_exclusive: assert property (
      @(posedge npu_clk) disable iff (!npu_rst_n) !(npu_active && npu_done)
   ) else $error("npu_active and npu_done high together");

endmodule

bind npu_control_top npu_control_checker u_checker (
   .npu_clk           (npu_clk),
   .npu_rst_n         (npu_rst_n),
   .act_mem_rd_en     (act_mem_rd_en),
   .act_mem_rd_bypass (act_mem_rd_bypass),
   .npu_active        (npu_active),
   .npu_done          (npu_done)
);

//--- design/npu_control_top.sv
`timescale 1ns/1ns

module npu_control_top #(
   parameter int IMG_DIM = 32
) (
   input  logic               npu_clk,
   input  logic               npu_rst_n,
   input  logic               cfg_write_row,
   input  npu_pkg::row_cnt_t  cfg_start_threshold,
   input  logic               softmax_result_valid,
   input  npu_pkg::class_t    softmax_class,
   output logic               npu_active,
   output logic               npu_done,
   output npu_pkg::layer_e    npu_layer_in_progress,
   output npu_pkg::row_cnt_t  img_num_rows_written,
   output npu_pkg::class_t    npu_class_predicted,
   output logic               act_mem_rd_en,
   output npu_pkg::act_addr_t act_mem_rd_addr,
   output logic               act_mem_rd_bypass
);
   import npu_pkg::*;

   layer_e    layer;
   logic      layer_req;
   logic      conv_ack;
   logic      fc_ack;
   logic      conv_req;
   act_addr_t conv_rel_addr;
   logic      conv_pad;
   logic      conv_gnt;
   logic      fc_req;
   act_addr_t fc_rel_addr;
   logic      fc_gnt;

   ////////////////////////////////////////
   // Layer sequencing
   ////////////////////////////////////////

   npu_layer_sequencer u_seq (
      .npu_clk               (npu_clk),
      .npu_rst_n             (npu_rst_n),
      .cfg_write_row         (cfg_write_row),
      .cfg_start_threshold   (cfg_start_threshold),
      .softmax_result_valid  (softmax_result_valid),
      .softmax_class         (softmax_class),
      .conv_ack              (conv_ack),
      .fc_ack                (fc_ack),
      .layer                 (layer),
      .layer_req             (layer_req),
      .npu_active            (npu_active),
      .npu_done              (npu_done),
      .npu_layer_in_progress (npu_layer_in_progress),
      .img_num_rows_written  (img_num_rows_written),
      .npu_class_predicted   (npu_class_predicted)
   );

   ////////////////////////////////////////
   // Layer walkers and read port
   ////////////////////////////////////////

   conv_window_walker #(
      .IMG_DIM (IMG_DIM)
   ) u_conv_walker (
      .npu_clk     (npu_clk),
      .npu_rst_n   (npu_rst_n),
      .layer       (layer),
      .layer_req   (layer_req),
      .conv_ack    (conv_ack),
      .rd_req      (conv_req),
      .rd_rel_addr (conv_rel_addr),
      .rd_pad      (conv_pad),
      .conv_gnt    (conv_gnt)
   );

   fc_vector_walker #(
      .IMG_DIM (IMG_DIM)
   ) u_fc_walker (
      .npu_clk     (npu_clk),
      .npu_rst_n   (npu_rst_n),
      .layer       (layer),
      .layer_req   (layer_req),
      .fc_ack      (fc_ack),
      .rd_req      (fc_req),
      .rd_rel_addr (fc_rel_addr),
      .fc_gnt      (fc_gnt)
   );

   act_rd_arbiter u_arb (
      .npu_clk           (npu_clk),
      .npu_rst_n         (npu_rst_n),
      .layer             (layer),
      .conv_req          (conv_req),
      .conv_rel_addr     (conv_rel_addr),
      .conv_pad          (conv_pad),
      .conv_gnt          (conv_gnt),
      .fc_req            (fc_req),
      .fc_rel_addr       (fc_rel_addr),
      .fc_gnt            (fc_gnt),
      .act_mem_rd_en     (act_mem_rd_en),
      .act_mem_rd_addr   (act_mem_rd_addr),
      .act_mem_rd_bypass (act_mem_rd_bypass)
   );

endmodule

//--- design/act_rd_arbiter.sv
`timescale 1ns/1ns

module act_rd_arbiter (
   input  logic               npu_clk,
   input  logic               npu_rst_n,
   input  npu_pkg::layer_e    layer,
   input  logic               conv_req,
   input  npu_pkg::act_addr_t conv_rel_addr,
   input  logic               conv_pad,
   output logic               conv_gnt,
   input  logic               fc_req,
   input  npu_pkg::act_addr_t fc_rel_addr,
   output logic               fc_gnt,
   output logic               act_mem_rd_en,
   output npu_pkg::act_addr_t act_mem_rd_addr,
   output logic               act_mem_rd_bypass
);
   import npu_pkg::*;

   act_addr_t sect_base;
   act_addr_t rel_addr;

   // Fixed priority, conv walker first
   assign conv_gnt = conv_req;
   assign fc_gnt   = fc_req && !conv_req;
   assign rel_addr = conv_gnt ? conv_rel_addr : fc_rel_addr;

   // Section written by the previous layer
   always_comb begin
      case (layer)
         LAYER_CONV2: sect_base = CONV1_OUT_BASE;
         LAYER_CONV3: sect_base = CONV2_OUT_BASE;
         LAYER_FC1:   sect_base = CONV3_OUT_BASE;
         LAYER_FC2:   sect_base = FC1_OUT_BASE;
         default:     sect_base = INPUT_IMAGE_BASE;
      endcase
   end

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         act_mem_rd_en     <= 1'b0;
         act_mem_rd_bypass <= 1'b0;
      end else begin
         act_mem_rd_en     <= conv_req || fc_req;
         act_mem_rd_bypass <= conv_gnt && conv_pad;
      end
   end

   always_ff @(posedge npu_clk) begin
      act_mem_rd_addr <= rel_addr + sect_base;
   end

endmodule

//--- design/fc_vector_walker.sv
`timescale 1ns/1ns

module fc_vector_walker #(
   parameter int IMG_DIM = 32
) (
   input  logic               npu_clk,
   input  logic               npu_rst_n,
   input  npu_pkg::layer_e    layer,
   input  logic               layer_req,
   output logic               fc_ack,
   output logic               rd_req,
   output npu_pkg::act_addr_t rd_rel_addr,
   input  logic               fc_gnt
);
   import npu_pkg::*;

   // Conv3 output after the last pool, flattened
   localparam int FC1_IN_LEN = CONV3_OUT_CH * (IMG_DIM / 8) * (IMG_DIM / 8);
   localparam int MAX_LEN    = (FC1_IN_LEN > FC2_IN_LEN) ? FC1_IN_LEN : FC2_IN_LEN;
   localparam int CNT_W      = $clog2(MAX_LEN);

   logic [CNT_W-1:0] rd_cnt;
   logic [CNT_W-1:0] cnt_last;
   logic             is_fc;

   assign is_fc    = (layer == LAYER_FC1) || (layer == LAYER_FC2);
   assign cnt_last = (layer == LAYER_FC1) ? CNT_W'(FC1_IN_LEN - 1) : CNT_W'(FC2_IN_LEN - 1);
   assign rd_req   = layer_req && is_fc && !fc_ack;

   // Input vector is read linearly
   assign rd_rel_addr = act_addr_t'(rd_cnt);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         rd_cnt <= '0;
         fc_ack <= 1'b0;
      end else begin
         if (fc_gnt) begin
            rd_cnt <= (rd_cnt == cnt_last) ? '0 : rd_cnt + CNT_W'(1);
         end
         if (!layer_req) begin
            fc_ack <= 1'b0;
         end else if (fc_gnt && (rd_cnt == cnt_last)) begin
            fc_ack <= 1'b1;
         end
      end
   end

endmodule

//--- design/conv_window_walker.sv
`timescale 1ns/1ns

module conv_window_walker #(
   parameter int IMG_DIM = 32
) (
   input  logic               npu_clk,
   input  logic               npu_rst_n,
   input  npu_pkg::layer_e    layer,
   input  logic               layer_req,
   output logic               conv_ack,
   output logic               rd_req,
   output npu_pkg::act_addr_t rd_rel_addr,
   output logic               rd_pad,
   input  logic               conv_gnt
);
   import npu_pkg::*;

   localparam int CW   = $clog2(IMG_DIM);
   localparam int DW   = CW + 1;
   localparam int QW   = CW - 1;
   localparam int CH_W = $clog2(CONV_IN_CH[2]);

   logic [DW-1:0]   dim;
   logic [QW-1:0]   quad_max;
   logic [CH_W-1:0] ch_max;
   logic            is_conv;

   logic [QW-1:0]   quad_row;
   logic [QW-1:0]   quad_col;
   logic [1:0]      quad_pos;
   logic [1:0]      filt_row;
   logic [CH_W-1:0] in_ch;
   logic [1:0]      filt_col;

   logic            col_wrap;
   logic            ch_wrap;
   logic            pix_last;
   logic            pos_wrap;
   logic            qcol_wrap;
   logic            layer_last;

   // Tap coordinates shifted by one so the top and left padding sit at zero
   logic [DW-1:0]   tap_row_p;
   logic [DW-1:0]   tap_col_p;
   logic [DW-1:0]   tap_row;
   logic [DW-1:0]   tap_col;

   // Each conv layer halves the width of the one before
   always_comb begin
      case (layer)
         LAYER_CONV2: begin
            dim    = DW'(IMG_DIM / 2);
            ch_max = CH_W'(CONV_IN_CH[1] - 1);
         end
         LAYER_CONV3: begin
            dim    = DW'(IMG_DIM / 4);
            ch_max = CH_W'(CONV_IN_CH[2] - 1);
         end
         default: begin
            dim    = DW'(IMG_DIM);
            ch_max = CH_W'(CONV_IN_CH[0] - 1);
         end
      endcase
      quad_max = QW'((dim >> 1) - DW'(1));
   end

   assign is_conv = layer inside {LAYER_CONV1, LAYER_CONV2, LAYER_CONV3};
   assign rd_req  = layer_req && is_conv && !conv_ack;

   ////////////////////////////////////////
   // Window counters
   ////////////////////////////////////////

   // Filter column fastest, then input channel, then filter row
   assign col_wrap   = (filt_col == 2'd2);
   assign ch_wrap    = col_wrap && (in_ch == ch_max);
   assign pix_last   = ch_wrap && (filt_row == 2'd2);
   assign pos_wrap   = pix_last && (quad_pos == 2'd3);
   assign qcol_wrap  = pos_wrap && (quad_col == quad_max);
   assign layer_last = qcol_wrap && (quad_row == quad_max);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         quad_row <= '0;
         quad_col <= '0;
         quad_pos <= '0;
         filt_row <= '0;
         in_ch    <= '0;
         filt_col <= '0;
      end else if (conv_gnt) begin
         filt_col <= col_wrap ? 2'd0 : filt_col + 2'd1;
         if (col_wrap) begin
            in_ch <= (in_ch == ch_max) ? '0 : in_ch + CH_W'(1);
         end
         if (ch_wrap) begin
            filt_row <= (filt_row == 2'd2) ? 2'd0 : filt_row + 2'd1;
         end
         // Four pixels of a 2x2 quad in a row, for the max-pool stage
         if (pix_last) begin
            quad_pos <= quad_pos + 2'd1;
         end
         if (pos_wrap) begin
            quad_col <= (quad_col == quad_max) ? '0 : quad_col + QW'(1);
         end
         if (qcol_wrap) begin
            quad_row <= (quad_row == quad_max) ? '0 : quad_row + QW'(1);
         end
      end
   end

   ////////////////////////////////////////
   // Tap position and address
   ////////////////////////////////////////

   assign tap_row_p = DW'({quad_row, quad_pos[1]}) + DW'(filt_row);
   assign tap_col_p = DW'({quad_col, quad_pos[0]}) + DW'(filt_col);
   assign tap_row   = tap_row_p - DW'(1);
   assign tap_col   = tap_col_p - DW'(1);

   assign rd_pad = (tap_row_p == '0) || (tap_row_p > dim) ||
                   (tap_col_p == '0) || (tap_col_p > dim);

   // Channel planes are stored one after another, row major inside
   assign rd_rel_addr = rd_pad ? '0 :
                        act_addr_t'(in_ch) * act_addr_t'(dim) * act_addr_t'(dim) +
                        act_addr_t'(tap_row) * act_addr_t'(dim) + act_addr_t'(tap_col);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         conv_ack <= 1'b0;
      end else if (!layer_req) begin
         conv_ack <= 1'b0;
      end else if (conv_gnt && layer_last) begin
         conv_ack <= 1'b1;
      end
   end

endmodule

//--- design/npu_layer_sequencer.sv
`timescale 1ns/1ns

module npu_layer_sequencer (
   input  logic              npu_clk,
   input  logic              npu_rst_n,
   input  logic              cfg_write_row,
   input  npu_pkg::row_cnt_t cfg_start_threshold,
   input  logic              softmax_result_valid,
   input  npu_pkg::class_t   softmax_class,
   input  logic              conv_ack,
   input  logic              fc_ack,
   output npu_pkg::layer_e   layer,
   output logic              layer_req,
   output logic              npu_active,
   output logic              npu_done,
   output npu_pkg::layer_e   npu_layer_in_progress,
   output npu_pkg::row_cnt_t img_num_rows_written,
   output npu_pkg::class_t   npu_class_predicted
);
   import npu_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_REQ,
      ST_RELEASE,
      ST_WAIT,
      ST_SOFTMAX,
      ST_DONE
   } seq_state_e;

   localparam int WAIT_W = $clog2(RESULT_WAIT_CYCLES);

   seq_state_e        state;
   layer_e            cur_layer;
   logic              fc1_second;
   logic [WAIT_W-1:0] wait_cnt;
   logic              walker_ack;
   logic              start_trig;
   logic              wait_last;

   // Run starts once enough rows are in, a zero threshold never starts
   assign start_trig = (img_num_rows_written >= cfg_start_threshold) &&
                       (cfg_start_threshold != '0);

   assign wait_last = (wait_cnt == WAIT_W'(RESULT_WAIT_CYCLES - 1));

   // Only the walker that serves the current layer answers
   assign walker_ack = (cur_layer inside {LAYER_CONV1, LAYER_CONV2, LAYER_CONV3}) ?
                       conv_ack : fc_ack;

   ////////////////////////////////////////
   // Layer FSM
   ////////////////////////////////////////

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         state      <= ST_IDLE;
         cur_layer  <= LAYER_IDLE;
         fc1_second <= 1'b0;
         wait_cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start_trig) begin
                  state     <= ST_REQ;
                  cur_layer <= LAYER_CONV1;
               end
            end
            ST_REQ: begin
               if (walker_ack) begin
                  state <= ST_RELEASE;
               end
            end
            ST_RELEASE: begin
               // Wait for the walker to drop its ack before moving on
               if (!walker_ack) begin
                  if (cur_layer == LAYER_FC2) begin
                     state     <= ST_SOFTMAX;
                     cur_layer <= LAYER_SOFTMAX;
                  end else begin
                     state    <= ST_WAIT;
                     wait_cnt <= '0;
                  end
               end
            end
            ST_WAIT: begin
               wait_cnt <= wait_cnt + WAIT_W'(1);
               if (wait_last) begin
                  state <= ST_REQ;
                  case (cur_layer)
                     LAYER_CONV1: cur_layer <= LAYER_CONV2;
                     LAYER_CONV2: cur_layer <= LAYER_CONV3;
                     LAYER_CONV3: cur_layer <= LAYER_FC1;
                     default: begin
                        // fc1 is run as two halves before fc2
                        fc1_second <= !fc1_second;
                        if (fc1_second) begin
                           cur_layer <= LAYER_FC2;
                        end
                     end
                  endcase
               end
            end
            ST_SOFTMAX: begin
               if (softmax_result_valid) begin
                  state     <= ST_DONE;
                  cur_layer <= LAYER_DONE;
               end
            end
            ST_DONE: begin
               // Next image write from the host rearms the unit
               if (cfg_write_row) begin
                  state     <= ST_IDLE;
                  cur_layer <= LAYER_IDLE;
               end
            end
            default: begin
               state     <= ST_IDLE;
               cur_layer <= LAYER_IDLE;
            end
         endcase
      end
   end

   // Host row counter, held clear while done
   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         img_num_rows_written <= '0;
      end else if (state == ST_DONE) begin
         img_num_rows_written <= '0;
      end else if (cfg_write_row) begin
         img_num_rows_written <= img_num_rows_written + 6'd1;
      end
   end

   always_ff @(posedge npu_clk) begin
      if (softmax_result_valid) begin
         npu_class_predicted <= softmax_class;
      end
   end

   assign layer                 = cur_layer;
   assign npu_layer_in_progress = cur_layer;
   assign layer_req             = (state == ST_REQ);
   assign npu_done              = (state == ST_DONE);
   assign npu_active            = (state != ST_IDLE) && (state != ST_DONE);

endmodule

//--- design/npu_pkg.sv
package npu_pkg;

   ////////////////////////////////////////
   // Layer encoding
   ////////////////////////////////////////

   // Codes are visible to the host through npu_layer_in_progress
   typedef enum logic [2:0] {
      LAYER_IDLE    = 3'd0,
      LAYER_CONV1   = 3'd1,
      LAYER_CONV2   = 3'd2,
      LAYER_CONV3   = 3'd3,
      LAYER_FC1     = 3'd4,
      LAYER_FC2     = 3'd5,
      LAYER_SOFTMAX = 3'd6,
      LAYER_DONE    = 3'd7
   } layer_e;

   typedef logic [12:0] act_addr_t;
   typedef logic [4:0]  class_t;
   typedef logic [5:0]  row_cnt_t;

   ////////////////////////////////////////
   // Network geometry
   ////////////////////////////////////////

   // Input channels of conv1, conv2 and conv3
   localparam int CONV_IN_CH [0:2] = '{3, 8, 16};

   // Channels leaving conv3, flattened into fc1
   localparam int CONV3_OUT_CH = 24;

   localparam int FC2_IN_LEN = 64;

   // Cycles given to the MAC array to write a layer's results back
   localparam int RESULT_WAIT_CYCLES = 32;

   ////////////////////////////////////////
   // Activation memory map
   ////////////////////////////////////////

   // Each layer reads the section written by the layer before it
   localparam act_addr_t INPUT_IMAGE_BASE = 13'd0;
   localparam act_addr_t CONV1_OUT_BASE   = 13'd3072;
   localparam act_addr_t CONV2_OUT_BASE   = 13'd5120;
   localparam act_addr_t CONV3_OUT_BASE   = 13'd6144;
   localparam act_addr_t FC1_OUT_BASE     = 13'd6528;

endpackage
